/* apu_pkg.sv */
`default_nettype none

package apu_pkg;

	localparam int data_w = 8;	// register and alu width
	localparam int gpr_n = 16;	// general registers
	localparam int op_w = 16;	// instruction word

	// halt instruction, also forced while apu_halt is high
	localparam logic [op_w-1:0] halt_op = '1;

	// opcode classes in bits 15..12
	localparam logic [3:0] cls_alu_imm = 4'd6;	// top of the imm range 0..6, fn in 14..12
	localparam logic [3:0] cls_unary = 4'd7;	// op in bits 7..6
	localparam logic [3:0] cls_alu_reg = 4'd8;	// fn in bits 6..4
	localparam logic [3:0] cls_jr = 4'd9;
	localparam logic [3:0] cls_out = 4'd10;
	localparam logic [3:0] cls_wait = 4'd11;

	// alu functions
	localparam logic [2:0] fn_ld = 3'd0;
	localparam logic [2:0] fn_and = 3'd1;
	localparam logic [2:0] fn_or = 3'd2;
	localparam logic [2:0] fn_xor = 3'd3;
	localparam logic [2:0] fn_add = 3'd4;
	localparam logic [2:0] fn_tst = 3'd5;	// and, flags only
	localparam logic [2:0] fn_cmp = 3'd6;	// sub, flags only
	localparam logic [2:0] fn_sub = 3'd7;	// reg form only

	// unary ops
	localparam logic [1:0] un_inc = 2'd0;
	localparam logic [1:0] un_dec = 2'd1;
	localparam logic [1:0] un_cpl = 2'd2;
	localparam logic [1:0] un_neg = 2'd3;

	// out ports, bits 7..4
	localparam logic [3:0] port_border = 4'd0;
	localparam logic [3:0] port_covox = 4'd1;
	localparam logic [3:0] port_timer = 4'd2;

	// wait pins, bits 4..0
	localparam logic [4:0] pin_one = 5'd0;
	localparam logic [4:0] pin_timer = 5'd1;

	typedef struct packed {
		logic z;
		logic c;	// carry or borrow
		logic n;	// result bit 7
	} alu_flags_t;

	typedef struct packed {
		logic [3:0] cls;
		logic [2:0] fn;
		logic [3:0] dst;
		logic [3:0] src;
		logic use_imm;
		logic [data_w-1:0] imm;	// also unary op and jump offset
		logic wr_dst;
		logic wr_flags;
		logic [3:0] port;
		logic port_wr;
		logic jr;
		logic [3:0] cond;
		logic wait_en;
		logic [4:0] pin;
		logic inv;
	} apu_ctrl_t;

endpackage

`default_nettype wire

/* apu_code_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_code_ram #(
	parameter int code_aw = 8
) (
	input wire clk,
	input wire arst_n,
	input wire code_wen,
	input wire [apu_pkg::data_w-1:0] code_wdata,
	input wire [code_aw:0] code_waddr,
	input wire [code_aw-1:0] rd_addr,	// pc_next from sequencer
	output logic [apu_pkg::op_w-1:0] opcode_r
);
	import apu_pkg::*;

	logic [data_w-1:0] lo_byte;	// even byte waits for its pair
	logic [op_w-1:0] mem [2**code_aw];

	always_ff @(posedge clk)
		if (code_wen && !code_waddr[0])
			lo_byte <= code_wdata;

	// odd byte completes the word
	always_ff @(posedge clk)
		if (code_wen && code_waddr[0])
			mem[code_waddr[code_aw:1]] <= {code_wdata, lo_byte};

	// registered read, next instruction fetched during the current one
	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
			opcode_r <= halt_op;
		else
			opcode_r <= mem[rd_addr];

endmodule

`default_nettype wire

/* apu_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_seq #(
	parameter int code_aw = 8
) (
	input wire clk,
	input wire arst_n,
	input wire apu_halt,
	input wire [apu_pkg::op_w-1:0] opcode_r,
	input wire apu_pkg::apu_ctrl_t ctrl,
	input wire apu_pkg::alu_flags_t flags,
	input wire timer_end,
	output logic [apu_pkg::op_w-1:0] opcode,
	output logic [code_aw-1:0] pc_next,
	output logic apu_rdy
);
	import apu_pkg::*;

	logic [code_aw-1:0] pc;
	logic [op_w-1:0] rel;	// sign-extended jump offset
	logic cond_ok;
	logic pin_val;

	assign opcode = apu_halt ? halt_op : opcode_r;	// halted core sees halt
	assign rel = {{(op_w-data_w){ctrl.imm[data_w-1]}}, ctrl.imm};

	always_comb
		case (ctrl.cond)
			4'd0: cond_ok = 1'b1;
			4'd1: cond_ok = flags.z;
			4'd2: cond_ok = flags.c;
			4'd3: cond_ok = !flags.z;
			4'd4: cond_ok = !flags.c && !flags.z;	// above
			4'd5: cond_ok = flags.c || flags.z;	// below or same
			4'd6: cond_ok = !flags.c;
			4'd7: cond_ok = flags.n;
			4'd8: cond_ok = !flags.n;
			default: cond_ok = 1'b0;	// 9..15 never
		endcase

	always_comb
		case (ctrl.pin)
			pin_one: pin_val = 1'b1;
			pin_timer: pin_val = timer_end;
			default: pin_val = 1'b0;
		endcase

	always_comb
		if (apu_halt)
			pc_next = '0;	// keeps word 0 in opcode_r for restart
		else if (opcode == halt_op)
			pc_next = pc;	// parked until halt toggles
		else if (ctrl.jr && cond_ok)
			pc_next = pc + rel[code_aw-1:0];	// relative to own pc
		else if (ctrl.wait_en && !(pin_val ^ ctrl.inv))
			pc_next = pc;	// stall on pin
		else
			pc_next = pc + 1'b1;

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
		begin
			pc <= '0;
			apu_rdy <= 1'b0;
		end
		else
		begin
			pc <= pc_next;
			apu_rdy <= (opcode == halt_op);
		end

endmodule

`default_nettype wire

/* apu_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_decode (
	input wire [apu_pkg::op_w-1:0] opcode,
	output apu_pkg::apu_ctrl_t ctrl
);
	import apu_pkg::*;

	logic [3:0] cls;

	assign cls = opcode[15:12];

	always_comb
	begin
		ctrl = '0;
		// raw fields whose meaning depends on class
		ctrl.cls = cls;
		ctrl.dst = opcode[11:8];
		ctrl.src = opcode[3:0];
		ctrl.imm = opcode[7:0];
		ctrl.cond = opcode[11:8];
		ctrl.port = opcode[7:4];
		ctrl.pin = opcode[4:0];
		ctrl.inv = opcode[11];

		if (cls <= cls_alu_imm)
		begin
			ctrl.fn = opcode[14:12];	// same bits as class
			ctrl.use_imm = 1'b1;
			ctrl.wr_dst = (ctrl.fn != fn_tst) && (ctrl.fn != fn_cmp);
			ctrl.wr_flags = (ctrl.fn != fn_ld);
		end
		else
			case (cls)
				cls_unary:
				begin
					// op taken from imm[7:6] by the alu
					ctrl.wr_dst = 1'b1;
					ctrl.wr_flags = 1'b1;
				end
				cls_alu_reg:
				begin
					ctrl.fn = opcode[6:4];
					ctrl.wr_dst = (ctrl.fn != fn_tst) && (ctrl.fn != fn_cmp);
					ctrl.wr_flags = (ctrl.fn != fn_ld);
				end
				cls_jr:
					ctrl.jr = 1'b1;
				cls_out:
					ctrl.port_wr = 1'b1;	// port chosen in io
				cls_wait:
					ctrl.wait_en = 1'b1;
				default: ;	// nop and halt leave every enable low
			endcase
	end

endmodule

`default_nettype wire

/* apu_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_regs (
	input wire clk,
	input wire arst_n,
	input wire apu_pkg::apu_ctrl_t ctrl,
	input wire [apu_pkg::data_w-1:0] alu_res,
	input wire apu_pkg::alu_flags_t alu_flags,
	output logic [apu_pkg::data_w-1:0] rd_dst,
	output logic [apu_pkg::data_w-1:0] rd_src,
	output apu_pkg::alu_flags_t flags
);
	import apu_pkg::*;

	logic [data_w-1:0] gpr [gpr_n];

	// async read ports, dst doubles as out source
	assign rd_dst = gpr[ctrl.dst];
	assign rd_src = gpr[ctrl.src];

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
		begin
			for (int i = 0; i < gpr_n; i++)
				gpr[i] <= '0;
			flags <= '0;
		end
		else
		begin
			if (ctrl.wr_dst)
				gpr[ctrl.dst] <= alu_res;
			if (ctrl.wr_flags)
				flags <= alu_flags;	// z c n together
		end

endmodule

`default_nettype wire

/* apu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_alu (
	input wire apu_pkg::apu_ctrl_t ctrl,
	input wire [apu_pkg::data_w-1:0] rd_dst,
	input wire [apu_pkg::data_w-1:0] rd_src,
	output logic [apu_pkg::data_w-1:0] alu_res,
	output apu_pkg::alu_flags_t alu_flags
);
	import apu_pkg::*;

	logic [data_w-1:0] arg;
	logic [data_w:0] sum;	// top bit is carry or borrow

	assign arg = ctrl.use_imm ? ctrl.imm : rd_src;

	always_comb
		if (ctrl.cls == cls_unary)
			case (ctrl.imm[7:6])	// operates on dst in place
				un_inc: sum = {1'b0, rd_dst} + 1'b1;
				un_dec: sum = {1'b0, rd_dst} - 1'b1;	// borrow on 0
				un_cpl: sum = {1'b0, ~rd_dst};
				un_neg: sum = '0 - {1'b0, rd_dst};	// borrow unless 0
			endcase
		else
			case (ctrl.fn)
				fn_ld: sum = {1'b0, arg};
				fn_and, fn_tst: sum = {1'b0, rd_dst & arg};
				fn_or: sum = {1'b0, rd_dst | arg};
				fn_xor: sum = {1'b0, rd_dst ^ arg};
				fn_add: sum = {1'b0, rd_dst} + {1'b0, arg};
				fn_cmp, fn_sub: sum = {1'b0, rd_dst} - {1'b0, arg};
			endcase

	assign alu_res = sum[data_w-1:0];
	assign alu_flags = '{z: (alu_res == '0), c: sum[data_w], n: alu_res[data_w-1]};

endmodule

`default_nettype wire

/* apu_io.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_io (
	input wire clk,
	input wire arst_n,
	input wire apu_pkg::apu_ctrl_t ctrl,
	input wire [apu_pkg::data_w-1:0] rd_dst,
	output logic [5:0] apu_border,
	output logic apu_border_we,
	output logic [apu_pkg::data_w-1:0] apu_covox,
	output logic apu_covox_we,
	output logic timer_end
);
	import apu_pkg::*;

	logic wr_border;
	logic wr_covox;
	logic wr_timer;
	logic [data_w-1:0] timer;	// countdown

	assign wr_border = ctrl.port_wr && (ctrl.port == port_border);
	assign wr_covox = ctrl.port_wr && (ctrl.port == port_covox);
	assign wr_timer = ctrl.port_wr && (ctrl.port == port_timer);
	assign timer_end = (timer == '0);

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
		begin
			apu_border_we <= 1'b0;
			apu_covox_we <= 1'b0;
			timer <= '0;
		end
		else
		begin
			apu_border_we <= wr_border;	// one cycle, with data
			apu_covox_we <= wr_covox;
			if (wr_timer)
				timer <= rd_dst;
			else if (!timer_end)
				timer <= timer - 1'b1;
		end

	// port values, valid with their strobe
	always_ff @(posedge clk)
	begin
		if (wr_border)
			apu_border <= rd_dst[5:0];	// low 6 bits only
		if (wr_covox)
			apu_covox <= rd_dst;
	end

endmodule

`default_nettype wire

/* apu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_top #(
	parameter int code_aw = 8	// code words = 2**code_aw
) (
	input wire clk,
	input wire arst_n,
	input wire apu_halt,
	input wire code_wen,
	input wire [apu_pkg::data_w-1:0] code_wdata,
	input wire [code_aw:0] code_waddr,	// byte address
	output logic apu_rdy,
	output logic [5:0] apu_border,
	output logic apu_border_we,
	output logic [apu_pkg::data_w-1:0] apu_covox,
	output logic apu_covox_we
);
	import apu_pkg::*;

	logic [op_w-1:0] opcode_r;	// ram output
	logic [op_w-1:0] opcode;	// after halt forcing
	logic [code_aw-1:0] pc_next;
	apu_ctrl_t ctrl;
	logic [data_w-1:0] rd_dst;
	logic [data_w-1:0] rd_src;
	logic [data_w-1:0] alu_res;
	alu_flags_t alu_flags;	// from alu
	alu_flags_t flags;	// registered
	logic timer_end;

	apu_code_ram #(.code_aw(code_aw)) code_ram0 (
		.clk, .arst_n, .code_wen, .code_wdata, .code_waddr,
		.rd_addr(pc_next), .opcode_r
	);

	apu_seq #(.code_aw(code_aw)) seq0 (
		.clk, .arst_n, .apu_halt, .opcode_r, .ctrl, .flags, .timer_end,
		.opcode, .pc_next, .apu_rdy
	);

	apu_decode decode0 (.opcode, .ctrl);

	apu_regs regs0 (
		.clk, .arst_n, .ctrl, .alu_res, .alu_flags, .rd_dst, .rd_src, .flags
	);

	apu_alu alu0 (.ctrl, .rd_dst, .rd_src, .alu_res, .alu_flags);

	apu_io io0 (
		.clk, .arst_n, .ctrl, .rd_dst,
		.apu_border, .apu_border_we, .apu_covox, .apu_covox_we, .timer_end
	);

endmodule

`default_nettype wire

/* apu_tb_props.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_tb_props (
	input wire clk,
	input wire arst_n,
	input wire apu_halt,
	input wire apu_rdy,
	input wire apu_border_we,
	input wire apu_covox_we
);
	int fail_cnt = 0;	// summed into the closing count line

	// only one out per cycle, so at most one strobe
	one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		!(apu_border_we && apu_covox_we))
	else
	begin
		fail_cnt++;
		$error("border and covox strobes high in the same cycle");
	end

	rdy_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
		apu_halt |=> apu_rdy)
	else
	begin
		fail_cnt++;
		$error("apu_rdy low one cycle after apu_halt");
	end

	quiet_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
		apu_halt |=> !apu_border_we && !apu_covox_we)	// halted cycle writes nothing
	else
	begin
		fail_cnt++;
		$error("port strobe in the cycle after a halted cycle");
	end

endmodule

`default_nettype wire

/* apu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module apu_tb;
	import apu_pkg::*;

	localparam int code_aw = 8;
	localparam int words = 2**code_aw;
	localparam int n_prog = 8;
	localparam int max_cycles = n_prog * (2 * words + words * 257);	// load plus worst-case waits

	typedef struct packed {
		int cyc;	// observed cycle, counted from halt release
		logic [3:0] port;
		logic [7:0] val;
	} port_ev_t;

	logic clk;
	logic arst_n;
	logic apu_halt;
	logic code_wen;
	logic [7:0] code_wdata;
	logic [code_aw:0] code_waddr;
	logic apu_rdy;
	logic [5:0] apu_border;
	logic apu_border_we;
	logic [7:0] apu_covox;
	logic apu_covox_we;

	logic [15:0] prog [words];
	int prog_len;
	int halt_cyc;	// model cycle of the final halt_op
	int errors = 0;
	int cycle_cnt = 0;
	port_ev_t ev_q [$];	// expected writes in order

	apu_top #(.code_aw(code_aw)) dut0 (
		.clk, .arst_n, .apu_halt, .code_wen, .code_wdata, .code_waddr,
		.apu_rdy, .apu_border, .apu_border_we, .apu_covox, .apu_covox_we
	);

	bind apu_top apu_tb_props props0 (
		.clk, .arst_n, .apu_halt, .apu_rdy, .apu_border_we, .apu_covox_we
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// 9-bit result, top bit is carry or borrow
	function automatic logic [8:0] alu_ref(input logic [2:0] fn, input logic [7:0] a,
		input logic [7:0] b);
		case (fn)
			3'd0: return {1'b0, b};
			3'd1, 3'd5: return {1'b0, a & b};
			3'd2: return {1'b0, a | b};
			3'd3: return {1'b0, a ^ b};
			3'd4: return {1'b0, a} + {1'b0, b};
			default: return {1'b0, a} - {1'b0, b};	// cmp and sub
		endcase
	endfunction

	function automatic logic [8:0] unary_result(input logic [1:0] op, input logic [7:0] a);
		case (op)
			2'd0: return {1'b0, a} + 9'd1;
			2'd1: return {1'b0, a} - 9'd1;
			2'd2: return {1'b0, ~a};
			default: return 9'd0 - {1'b0, a};
		endcase
	endfunction

	function automatic logic jump_taken(input logic [3:0] cond, input logic z, input logic c,
		input logic n);
		case (cond)
			4'd0: return 1'b1;
			4'd1: return z;
			4'd2: return c;
			4'd3: return !z;
			4'd4: return !c && !z;
			4'd5: return c || z;
			4'd6: return !c;
			4'd7: return n;
			4'd8: return !n;
			default: return 1'b0;
		endcase
	endfunction

	task automatic expect_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else
		begin
			errors++;
			$display("FAILED %0t %s: got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	// prologue sets timer, all regs and flags, body is random, forward jumps only
	task automatic gen_program();
		int pos;
		int halt_idx;
		int max_off;
		halt_idx = 35 + $urandom % 24;
		prog[0] = {4'h0, 4'd0, 8'h00};	// ld r0,#0
		prog[1] = {cls_out, 4'd0, port_timer, 4'h0};	// clear leftover timer
		for (int i = 0; i < gpr_n; i++)
			prog[2 + i] = {4'h0, 4'(i), 8'($urandom)};
		prog[18] = {1'b0, fn_add, 4'($urandom), 8'($urandom)};	// defined flags
		pos = 19;
		while (pos < halt_idx)
		begin
			case ($urandom % 10)
				0, 1: prog[pos] = {1'b0, 3'($urandom % 7), 4'($urandom), 8'($urandom)};
				2: prog[pos] = {cls_unary, 12'($urandom)};
				3: prog[pos] = {cls_alu_reg, 12'($urandom)};
				4:
				begin
					max_off = (halt_idx - pos > 127) ? 127 : halt_idx - pos;
					prog[pos] = {cls_jr, 4'($urandom), 8'(1 + $urandom % max_off)};
				end
				5, 6:
					case ($urandom % 4)
						0: prog[pos] = {cls_out, 4'($urandom), port_border, 4'($urandom)};
						3: prog[pos] = {cls_out, 4'($urandom), 4'(3 + $urandom % 13), 4'h0};
						default: prog[pos] = {cls_out, 4'($urandom), port_covox, 4'h5};
					endcase
				7:
					case ($urandom % 3)
						0: prog[pos] = {cls_wait, 1'b0, 6'($urandom), pin_one};
						1: prog[pos] = {cls_wait, 1'b1, 6'($urandom), 5'(2 + $urandom % 30)};
						default: prog[pos] = {cls_wait, 1'b0, 6'($urandom), pin_timer};
					endcase
				8:
					if (pos + 1 < halt_idx)
					begin
						prog[pos] = {cls_out, 4'($urandom), port_timer, 4'h0};
						pos++;
						prog[pos] = {cls_wait, 1'b0, 6'($urandom), pin_timer};	// stall v cycles
					end
					else
						prog[pos] = {4'(12 + $urandom % 3), 12'($urandom)};
				default: prog[pos] = {4'(12 + $urandom % 3), 12'($urandom)};	// nop
			endcase
			pos++;
		end
		prog[halt_idx] = halt_op;
		prog_len = halt_idx + 1;
	endtask

	// instruction model, one cycle per instruction plus wait stalls
	task automatic model_run();
		logic [7:0] r [16];
		logic [15:0] op;
		logic [8:0] res;
		logic [2:0] fn;
		logic z, c, n, wd, wf, pin_hi, tmr_ld;
		logic [7:0] tmr;
		int pc, nxt, cyc;
		ev_q.delete();
		foreach (r[i])
			r[i] = 8'h00;
		{z, c, n} = 3'b000;
		tmr = 8'h00;
		pc = 0;
		cyc = 0;
		while (prog[pc] != halt_op)
		begin
			op = prog[pc];
			nxt = pc + 1;
			tmr_ld = 1'b0;
			if (op[15:12] <= cls_alu_reg)
			begin
				if (op[15:12] == cls_unary)
				begin
					res = unary_result(op[7:6], r[op[11:8]]);
					wd = 1'b1;
					wf = 1'b1;
				end
				else
				begin
					fn = op[15] ? op[6:4] : op[14:12];
					res = alu_ref(fn, r[op[11:8]], op[15] ? r[op[3:0]] : op[7:0]);
					wd = (fn != fn_tst) && (fn != fn_cmp);
					wf = (fn != fn_ld);
				end
				if (wd)
					r[op[11:8]] = res[7:0];
				if (wf)
					{z, c, n} = {res[7:0] == 8'h00, res[8], res[7]};
			end
			else if (op[15:12] == cls_jr && jump_taken(op[11:8], z, c, n))
				nxt = pc + $signed(op[7:0]);
			else if (op[15:12] == cls_out && op[7:4] == port_timer)
				tmr_ld = 1'b1;
			else if (op[15:12] == cls_out && op[7:4] <= port_covox)
				ev_q.push_back(port_ev_t'{cyc + 1, op[7:4], r[op[11:8]]});	// seen next cycle
			else if (op[15:12] == cls_wait)
			begin
				pin_hi = (op[4:0] == pin_one) || (op[4:0] == pin_timer && tmr == 8'h00);
				if (!(pin_hi ^ op[11]))
					nxt = pc;
			end
			if (tmr_ld)
				tmr = r[op[11:8]];
			else if (tmr != 8'h00)
				tmr = tmr - 8'd1;
			pc = nxt;
			cyc++;
		end
		halt_cyc = cyc;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog_len; i++)
			for (int b = 0; b < 2; b++)
			begin
				@(posedge clk);
				#2;
				code_wen = 1'b1;
				code_waddr = (code_aw+1)'(2 * i + b);	// low byte first
				code_wdata = b ? prog[i][15:8] : prog[i][7:0];
			end
		@(posedge clk);
		#2;
		code_wen = 1'b0;
	endtask

	// release halt, check every cycle, abort_at 0 runs to the halt_op
	task automatic run_program(input int abort_at);
		int cyc;
		int idx;
		logic exp_b;
		logic exp_c;
		cyc = 0;
		idx = 0;
		@(posedge clk);
		#2;
		apu_halt = 1'b0;
		do
		begin
			@(posedge clk);
			#2;
			cyc++;
			exp_b = 1'b0;
			exp_c = 1'b0;
			if (idx < ev_q.size() && ev_q[idx].cyc == cyc)
			begin
				exp_b = (ev_q[idx].port == port_border);
				exp_c = !exp_b;
			end
			expect_eq("apu_border_we", apu_border_we, exp_b);
			expect_eq("apu_covox_we", apu_covox_we, exp_c);
			expect_eq("apu_rdy", apu_rdy, cyc > halt_cyc);
			if (exp_b)
				expect_eq("apu_border", apu_border, ev_q[idx].val[5:0]);
			if (exp_c)
				expect_eq("apu_covox", apu_covox, ev_q[idx].val);
			if (exp_b || exp_c)
				idx++;
		end
		while (!apu_rdy && cyc != abort_at);
		if (abort_at == 0)
		begin
			assert (idx == ev_q.size()) else
			begin
				errors++;
				$display("only %0d of %0d expected port writes were seen", idx, ev_q.size());
			end
		end
		apu_halt = 1'b1;	// pc back to word 0
		repeat (4)
		begin
			@(posedge clk);
			#2;
			expect_eq("apu_border_we", apu_border_we, 1'b0);
			expect_eq("apu_covox_we", apu_covox_we, 1'b0);
			expect_eq("apu_rdy", apu_rdy, 1'b1);
		end
	endtask

	initial
	begin
		while (cycle_cnt < max_cycles)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, program never reached its halt", cycle_cnt);
		$display("errors: %0d check failures, %0d property failures", errors,
			dut0.props0.fail_cnt);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hd190));
		arst_n = 1'b0;
		apu_halt = 1'b1;	// held through reset and loading
		code_wen = 1'b0;
		code_wdata = 8'h00;
		code_waddr = '0;
		repeat (10) @(posedge clk);
		#2;
		arst_n = 1'b1;
		for (int p = 0; p < n_prog; p++)
		begin
			gen_program();
			model_run();
			load_program();
			run_program(0);
			run_program(1 + $urandom % halt_cyc);	// halted mid-run
			run_program(0);	// restart from word 0
		end
		$display("errors: %0d check failures, %0d property failures", errors,
			dut0.props0.fail_cnt);
		if (errors == 0 && dut0.props0.fail_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* apu.f */
apu_pkg.sv
apu_code_ram.sv
apu_seq.sv
apu_decode.sv
apu_regs.sv
apu_alu.sv
apu_io.sv
apu_top.sv
apu_tb_props.sv
apu_tb.sv

/* Bender.yml */
package:
  name: apu

sources:
  - apu_pkg.sv
  - apu_code_ram.sv
  - apu_seq.sv
  - apu_decode.sv
  - apu_regs.sv
  - apu_alu.sv
  - apu_io.sv
  - apu_top.sv
  - target: simulation
    files:
      - apu_tb_props.sv
      - apu_tb.sv
